/* src/cpuPkg.sv */
package cpuPkg;

    // Major opcodes
    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    // ALU operation codes, laid out as {alternate bit, funct3}
    localparam logic [3:0] aluAdd  = 4'b0000;
    localparam logic [3:0] aluSll  = 4'b0001;
    localparam logic [3:0] aluSlt  = 4'b0010;
    localparam logic [3:0] aluSltu = 4'b0011;
    localparam logic [3:0] aluXor  = 4'b0100;
    localparam logic [3:0] aluSrl  = 4'b0101;
    localparam logic [3:0] aluOr   = 4'b0110;
    localparam logic [3:0] aluAnd  = 4'b0111;
    localparam logic [3:0] aluSub  = 4'b1000;
    localparam logic [3:0] aluSra  = 4'b1101;

    // Memory depths in 32-bit words
    localparam int imemWords = 64;
    localparam int dmemWords = 64;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields;

    // Store immediate lives in funct7 and rd of the R view
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields;

    // One fetched word, seen through either field layout
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instrWord;

endpackage

/* src/programCounter.sv */
`timescale 1ns/100ps

module programCounter (
    input  logic        CLK,
    input  logic        RST,
    input  logic        halt,
    output logic [31:0] pc,
    output logic        halted
);

    // Byte address of the instruction being executed
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (!halt && !halted) begin
            pc <= pc + 32'd4;
        end
    end

    // Sticky halt, only reset clears it
    always_ff @(posedge CLK) begin
        if (RST) begin
            halted <= 1'b0;
        end else if (halt) begin
            halted <= 1'b1;
        end
    end

    // Fetch works on whole words only
    pcAligned: assert property (@(posedge CLK) disable iff (RST) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

/* src/instrMem.sv */
`timescale 1ns/100ps

module instrMem (
    input  logic                                    CLK,
    input  logic                                    progWe,
    input  logic [$clog2(cpuPkg::imemWords)-1:0]    progAddr,
    input  logic [31:0]                             progData,
    input  logic [31:0]                             addr,
    output logic [31:0]                             instr
);

    localparam int idxW = $clog2(cpuPkg::imemWords);

    logic [31:0] mem [cpuPkg::imemWords];

    // Unloaded words stay zero and read as the halt word
    initial begin
        for (int i = 0; i < cpuPkg::imemWords; i++) begin
            mem[i] = '0;
        end
    end

    // Program load port
    always @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[addr[idxW+1:2]]; // Word index from byte address

endmodule

/* src/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        CLK,
    input  logic        RST,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 never written
            regs[rd] <= wd;
        end
    end

    // Asynchronous read ports
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Whatever the decoder sends, x0 holds zero
    x0Zero: assert property (@(posedge CLK) disable iff (RST) regs[0] == '0)
        else $error("x0 holds nonzero value %h", regs[0]);

endmodule

/* src/dataMem.sv */
`timescale 1ns/100ps

module dataMem (
    input  logic        CLK,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wd,
    output logic [31:0] rd
);

    localparam int idxW = $clog2(cpuPkg::dmemWords);

    logic [31:0]     mem [cpuPkg::dmemWords];
    logic [idxW-1:0] wordIdx;

    assign wordIdx = addr[idxW+1:2]; // Byte address to word index

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    // Combinational read for lw write-back
    assign rd = mem[wordIdx];

    // Only sw reaches here, so the ALU address must be word aligned
    storeAligned: assert property (@(posedge CLK) we |-> addr[1:0] == 2'b00)
        else $error("misaligned store address %h", addr);

endmodule

/* src/controlDecoder.sv */
`timescale 1ns/100ps

module controlDecoder (
    input  cpuPkg::instrWord instr,
    output logic             regWe,
    output logic             aluSrcImm,
    output logic             memRead,
    output logic             memWrite,
    output logic [3:0]       aluOp,
    output logic [31:0]      imm,
    output logic             halt
);

    // funct3 plus the alternate bit; sub only exists for R-type
    function automatic logic [3:0] mapOp(input logic [2:0] f3, input logic alt,
                                         input logic subOk);
        if (f3 == 3'b000) begin
            return (alt && subOk) ? cpuPkg::aluSub : cpuPkg::aluAdd;
        end
        if (f3 == 3'b101) begin
            return alt ? cpuPkg::aluSra : cpuPkg::aluSrl;
        end
        return {1'b0, f3};
    endfunction

    always_comb begin
        regWe     = 1'b0;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluOp     = cpuPkg::aluAdd;
        imm       = '0;
        case (instr.rType.opcode)
            cpuPkg::opR: begin
                regWe = 1'b1;
                aluOp = mapOp(instr.rType.funct3, instr.rType.funct7[5], 1'b1);
            end
            cpuPkg::opImm: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = mapOp(instr.iType.funct3, instr.rType.funct7[5], 1'b0);
                imm       = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            cpuPkg::opLoad: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                imm       = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            cpuPkg::opStore: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                imm = {{20{instr.rType.funct7[6]}}, instr.rType.funct7, instr.rType.rd};
            end
            default: ; // Unknown opcode, nothing written
        endcase
    end

    assign halt = (instr == '0);

endmodule

/* src/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  aluOp,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Shift amount is five bits

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: begin
                result = a + b;
            end
            cpuPkg::aluSub: begin
                result = a - b;
            end
            cpuPkg::aluSll: begin
                result = a << shamt;
            end
            cpuPkg::aluSlt: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            cpuPkg::aluSltu: begin
                result = {31'd0, a < b};
            end
            cpuPkg::aluXor: begin
                result = a ^ b;
            end
            cpuPkg::aluSrl: begin
                result = a >> shamt;
            end
            cpuPkg::aluSra: begin
                result = $unsigned($signed(a) >>> shamt); // Sign fill
            end
            cpuPkg::aluOr: begin
                result = a | b;
            end
            cpuPkg::aluAnd: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* src/singleCpu.sv */
`timescale 1ns/100ps

module singleCpu (
    input  logic                                    CLK,
    input  logic                                    RST,
    input  logic                                    progWe,
    input  logic [$clog2(cpuPkg::imemWords)-1:0]    progAddr,
    input  logic [31:0]                             progData,
    output logic [31:0]                             pcOut,
    output logic                                    wbValid,
    output logic [4:0]                              wbReg,
    output logic [31:0]                             wbData,
    output logic                                    memWe,
    output logic [31:0]                             memAddr,
    output logic [31:0]                             memWData,
    output logic                                    halted
);

    cpuPkg::instrWord instr;

    logic [31:0] pc;
    logic        regWe, aluSrcImm, memRead, memWrite, halt;
    logic [3:0]  aluOp;
    logic [31:0] imm, rs1Data, rs2Data, aluB, aluResult, memRData;
    logic        execEn;

    // Nothing commits while held in reset or after the halt word
    assign execEn = !RST && !halted;

    programCounter pcReg (.CLK(CLK), .RST(RST), .halt(halt), .pc(pc), .halted(halted));

    instrMem imem (.CLK(CLK), .progWe(progWe), .progAddr(progAddr), .progData(progData),
                   .addr(pc), .instr(instr));

    controlDecoder dec (.instr(instr), .regWe(regWe), .aluSrcImm(aluSrcImm),
                        .memRead(memRead), .memWrite(memWrite), .aluOp(aluOp),
                        .imm(imm), .halt(halt));

    regFile rf (.CLK(CLK), .RST(RST), .rs1(instr.rType.rs1), .rs2(instr.rType.rs2),
                .rd(instr.rType.rd), .we(wbValid), .wd(wbData),
                .rs1Data(rs1Data), .rs2Data(rs2Data));

    assign aluB = aluSrcImm ? imm : rs2Data; // Operand select

    alu alu0 (.a(rs1Data), .b(aluB), .aluOp(aluOp), .result(aluResult));

    dataMem dmem (.CLK(CLK), .we(memWe), .addr(aluResult), .wd(rs2Data), .rd(memRData));

    // Write-back select and observation outputs
    assign wbData   = memRead ? memRData : aluResult;
    assign wbValid  = regWe && execEn;
    assign wbReg    = instr.rType.rd;
    assign memWe    = memWrite && execEn;
    assign memAddr  = aluResult;
    assign memWData = rs2Data;
    assign pcOut    = pc;

endmodule

/* dv/singleCpuTb.sv */
`timescale 1ns/100ps

module singleCpuTb;

    localparam int maxCycles = 400; // All tests take about 150 cycles

    logic        CLK = 1'b0;
    logic        RST = 1'b1;
    logic        progWe = 1'b0;
    logic [5:0]  progAddr = '0;
    logic [31:0] progData = '0;
    logic [31:0] pcOut, wbData, memAddr, memWData;
    logic [4:0]  wbReg;
    logic        wbValid, memWe, halted;
    int          errors = 0;
    int          cycleCount = 0;

    // Program words and the effect each one must show
    logic [31:0] prog[$];
    bit          expStore[$];
    logic [31:0] expA[$];    // Register index, or store address
    logic [31:0] expData[$];

    singleCpu UUT (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: tests still running after %0d clock cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Reference results from the RV32I operation rules
    function automatic logic [31:0] refOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0]; // Sign fill
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic logError(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic clearProgram();
        prog.delete();
        expStore.delete();
        expA.delete();
        expData.delete();
    endtask

    task automatic addOp(input logic [31:0] word, input bit isStore, input logic [31:0] a,
                         input logic [31:0] data);
        prog.push_back(word);
        expStore.push_back(isStore);
        expA.push_back(a);
        expData.push_back(data);
    endtask

    task automatic addReg(input logic [2:0] f3, input logic alt, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [4:0] rd,
                          input logic [31:0] a, input logic [31:0] b);
        addOp({1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011}, 1'b0, rd, refOp(f3, alt, a, b));
    endtask

    // Imm bit 10 selects srai over srli
    task automatic addImm(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
                          input logic [4:0] rd, input logic [31:0] a);
        addOp({imm, rs1, f3, rd, 7'b0010011}, 1'b0, rd,
              refOp(f3, f3 == 3'd5 && imm[10], a, sext12(imm)));
    endtask

    task automatic addLoad(input logic [11:0] off, input logic [4:0] rs1, input logic [4:0] rd,
                           input logic [31:0] data);
        addOp({off, rs1, 3'b010, rd, 7'b0000011}, 1'b0, rd, data);
    endtask

    task automatic addStoreOp(input logic [11:0] off, input logic [4:0] rs2,
                              input logic [4:0] rs1, input logic [31:0] base,
                              input logic [31:0] data);
        addOp({off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011}, 1'b1,
              base + sext12(off), data);
    endtask

    // Constant built 11, 11 and 10 bits at a time
    task automatic addConst(input logic [4:0] rd, input logic [31:0] v);
        addImm(3'd0, {1'b0, v[31:21]}, 5'd0, rd, 32'd0);
        addImm(3'd1, 12'd11, rd, rd, {21'd0, v[31:21]});
        addImm(3'd6, {1'b0, v[20:10]}, rd, rd, {10'd0, v[31:21], 11'd0});
        addImm(3'd1, 12'd10, rd, rd, {10'd0, v[31:10]});
        addImm(3'd6, {2'b0, v[9:0]}, rd, rd, {v[31:10], 10'd0});
    endtask

    task automatic checkIdle();
        assert (!wbValid && !memWe && !halted && pcOut == 32'd0)
            else logError($sformatf("active in reset: wbValid=%b memWe=%b halted=%b pc=%h",
                                    wbValid, memWe, halted, pcOut));
    endtask

    // Program plus a closing halt word, loaded while RST is high
    task automatic loadProgram();
        RST = 1'b1;
        @(posedge CLK);
        #2;
        for (int i = 0; i <= prog.size(); i++) begin
            progWe   = 1'b1;
            progAddr = 6'(i);
            progData = (i < prog.size()) ? prog[i] : 32'd0;
            @(negedge CLK);
            checkIdle();
            @(posedge CLK);
            #2;
        end
        progWe = 1'b0;
        RST    = 1'b0;
    endtask

    task automatic holdReset(input int n);
        RST = 1'b1;
        @(posedge CLK);
        #2;
        repeat (n) begin
            @(negedge CLK);
            checkIdle();
            @(posedge CLK);
            #2;
        end
        RST = 1'b0;
    endtask

    // Step k runs the word at byte address 4k
    task automatic checkSteps(input int count);
        logic [31:0] a;
        logic [31:0] d;
        for (int k = 0; k < count; k++) begin
            a = expA[k];
            d = expData[k];
            @(negedge CLK);
            assert (pcOut == 32'(4 * k))
                else logError($sformatf("step %0d pcOut %h, expected %h", k, pcOut, 4 * k));
            if (expStore[k]) begin
                assert (memWe && !wbValid && memAddr == a && memWData == d)
                    else logError($sformatf("step %0d store %b @%h=%h, expected @%h=%h",
                                            k, memWe, memAddr, memWData, a, d));
            end else begin
                assert (wbValid && !memWe && wbReg == a[4:0] && wbData == d)
                    else logError($sformatf("step %0d write %b x%0d=%h, expected x%0d=%h",
                                            k, wbValid, wbReg, wbData, a[4:0], d));
            end
            @(posedge CLK);
            #2;
        end
    endtask

    // Halt word cycle, then halted set with pc frozen
    task automatic checkHalt(input int holdCycles);
        logic [31:0] haltPc;
        haltPc = 32'(4 * prog.size());
        @(negedge CLK);
        assert (!wbValid && !memWe && pcOut == haltPc)
            else logError($sformatf("halt word at %h: pc %h wbValid %b memWe %b",
                                    haltPc, pcOut, wbValid, memWe));
        @(posedge CLK);
        #2;
        repeat (holdCycles) begin
            @(negedge CLK);
            assert (halted && !wbValid && !memWe && pcOut == haltPc)
                else logError($sformatf("after halt: halted %b pc %h wbValid %b memWe %b",
                                        halted, pcOut, wbValid, memWe));
            @(posedge CLK);
            #2;
        end
    endtask

    task automatic runProgram(input int holdCycles);
        loadProgram();
        checkSteps(prog.size());
        checkHalt(holdCycles);
    endtask

    task automatic testRType();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom | 32'h8000_0000; // Opposite signs split slt from sltu
        b = ($urandom & 32'h7fff_ffff) | 32'h1; // Odd, so the shift amount is never zero
        clearProgram();
        addConst(5'd1, a);
        addConst(5'd2, b);
        addReg(3'd0, 1'b0, 5'd1, 5'd2, 5'd3, a, b);
        addReg(3'd0, 1'b1, 5'd1, 5'd2, 5'd4, a, b);
        addReg(3'd1, 1'b0, 5'd1, 5'd2, 5'd5, a, b);
        addReg(3'd2, 1'b0, 5'd1, 5'd2, 5'd6, a, b);
        addReg(3'd3, 1'b0, 5'd1, 5'd2, 5'd7, a, b);
        addReg(3'd4, 1'b0, 5'd1, 5'd2, 5'd8, a, b);
        addReg(3'd5, 1'b0, 5'd1, 5'd2, 5'd9, a, b);
        addReg(3'd5, 1'b1, 5'd1, 5'd2, 5'd10, a, b);
        addReg(3'd6, 1'b0, 5'd1, 5'd2, 5'd11, a, b);
        addReg(3'd7, 1'b0, 5'd1, 5'd2, 5'd12, a, b);
        addReg(3'd2, 1'b0, 5'd2, 5'd1, 5'd13, b, a);
        addReg(3'd3, 1'b0, 5'd2, 5'd1, 5'd14, b, a);
        runProgram(1);
    endtask

    task automatic testIType();
        logic [31:0] a;
        logic [31:0] b;
        a = sext12(12'(-1234));
        b = 32'h5a3;
        clearProgram();
        addImm(3'd0, 12'(-1234), 5'd0, 5'd1, 32'd0);
        addImm(3'd0, 12'h5a3, 5'd0, 5'd2, 32'd0);
        addImm(3'd0, 12'(-7), 5'd1, 5'd3, a);
        addImm(3'd2, 12'(-5), 5'd1, 5'd4, a);
        addImm(3'd3, 12'(-5), 5'd1, 5'd5, a);
        addImm(3'd2, 12'(-1), 5'd2, 5'd6, b);
        addImm(3'd3, 12'(-1), 5'd2, 5'd7, b);
        addImm(3'd4, 12'(-1), 5'd1, 5'd8, a);
        addImm(3'd6, 12'h800, 5'd2, 5'd9, b);
        addImm(3'd7, 12'h7f0, 5'd1, 5'd10, a);
        addImm(3'd1, 12'd20, 5'd2, 5'd11, b);
        addImm(3'd5, 12'd4, 5'd1, 5'd12, a);
        addImm(3'd5, 12'h404, 5'd1, 5'd13, a);
        runProgram(1);
    endtask

    task automatic testZeroReg();
        clearProgram();
        addImm(3'd0, 12'h155, 5'd0, 5'd0, 32'd0); // Shows on wbReg 0 but never lands
        addImm(3'd0, 12'd77, 5'd0, 5'd1, 32'd0);
        addReg(3'd0, 1'b0, 5'd1, 5'd0, 5'd2, 32'd77, 32'd0);
        addReg(3'd0, 1'b0, 5'd0, 5'd1, 5'd3, 32'd0, 32'd77);
        runProgram(1);
    endtask

    task automatic testStoreLoad();
        logic [31:0] neg;
        neg = sext12(12'(-752));
        clearProgram();
        addStoreOp(12'd0, 5'd0, 5'd0, 32'd0, 32'd0); // Word 0 is a store during reset too
        addImm(3'd0, 12'h123, 5'd0, 5'd1, 32'd0);
        addImm(3'd0, 12'(-752), 5'd0, 5'd2, 32'd0);
        addImm(3'd0, 12'd16, 5'd0, 5'd5, 32'd0);
        addStoreOp(12'd0, 5'd1, 5'd5, 32'd16, 32'h123);
        addStoreOp(12'd8, 5'd2, 5'd5, 32'd16, neg);
        addStoreOp(12'(-4), 5'd5, 5'd5, 32'd16, 32'd16);
        addStoreOp(12'd40, 5'd2, 5'd5, 32'd16, neg); // Offset spans both imm fields
        addLoad(12'd0, 5'd5, 5'd6, 32'h123);
        addLoad(12'd8, 5'd5, 5'd7, neg);
        addLoad(12'(-4), 5'd5, 5'd8, 32'd16);
        addLoad(12'd40, 5'd5, 5'd9, neg);
        runProgram(1);
    endtask

    task automatic testHalt();
        clearProgram();
        addImm(3'd0, 12'd5, 5'd0, 5'd1, 32'd0);
        addImm(3'd0, 12'd3, 5'd1, 5'd2, 32'd5);
        addReg(3'd0, 1'b0, 5'd1, 5'd2, 5'd3, 32'd5, 32'd8);
        addReg(3'd0, 1'b1, 5'd1, 5'd2, 5'd4, 32'd5, 32'd8);
        runProgram(10);
    endtask

    task automatic testReset();
        clearProgram();
        addImm(3'd0, 12'd9, 5'd0, 5'd1, 32'd0);
        addImm(3'd0, 12'd9, 5'd1, 5'd1, 32'd9);
        addImm(3'd0, 12'd9, 5'd1, 5'd1, 32'd18);
        addImm(3'd0, 12'd9, 5'd1, 5'd1, 32'd27);
        loadProgram();
        checkSteps(3);
        holdReset(2); // Restart from address 0 with cleared registers
        checkSteps(prog.size());
        checkHalt(1);
    endtask

    initial begin
        void'($urandom(32'h4e7f_6cbb));
        testRType();
        testIType();
        testZeroReg();
        testStoreLoad();
        testHalt();
        testReset();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
src/cpuPkg.sv
src/programCounter.sv
src/instrMem.sv
src/regFile.sv
src/dataMem.sv
src/controlDecoder.sv
src/alu.sv
src/singleCpu.sv
dv/singleCpuTb.sv

/* Bender.yml */
package:
  name: single_cpu

sources:
  - src/cpuPkg.sv
  - src/programCounter.sv
  - src/instrMem.sv
  - src/regFile.sv
  - src/dataMem.sv
  - src/controlDecoder.sv
  - src/alu.sv
  - src/singleCpu.sv
  - target: test
    files:
      - dv/singleCpuTb.sv
